// File: rtl/mem_params.svh
// Memory subsystem parameters

`ifndef MEM_PARAMS_SVH
`define MEM_PARAMS_SVH

// Cache geometry
// log2 of the number of one-word lines
`define MEM_DCACHE_INDEX_BITS 4

// Config register map
`define MEM_CFG_ADDR_CTRL   1'b0
`define MEM_CFG_ADDR_REGION 1'b1

// Region nibble after reset
`define MEM_CFG_REGION_RESET 4'h1

`endif

// File: rtl/pipe_pkg.sv
// Pipeline-facing types
`default_nettype none

package pipe_pkg;

	// Access width of a load or store
	typedef enum logic [1:0] {
		MEMW_1 = 2'd0,
		MEMW_2 = 2'd1,
		MEMW_4 = 2'd2
	} mem_width_e;

	typedef logic [4:0] reg_index_t;

	// Item handed over by execute
	typedef struct packed {
		logic        strobe;
		logic [31:0] pc;
		logic [31:0] rd;
		reg_index_t  inst_rd;
		logic [31:0] mem_address;
		logic        mem_read;
		logic        mem_write;
		logic        mem_flush;
		logic        mem_signed;
		mem_width_e  mem_width;
		reg_index_t  mem_inst_rd;
	} execute_data_t;

	// Result passed on to writeback
	typedef struct packed {
		logic        strobe;
		logic [31:0] pc;
		logic [31:0] rd;
		reg_index_t  inst_rd;
	} memory_data_t;

	typedef enum logic {
		IDLE,
		FLUSH
	} stage_state_e;

endpackage

`default_nettype wire

// File: rtl/bus_pkg.sv
// Bus and cache control types
`default_nettype none

package bus_pkg;

	// Level request held until ready
	typedef struct packed {
		logic        request;
		logic        rw;
		logic [31:0] address;
		logic [31:0] wdata;
		logic [3:0]  wmask;
	} bus_req_t;

	// Single-cycle register write
	typedef struct packed {
		logic        write;
		logic        addr;
		logic [31:0] wdata;
	} cfg_write_t;

	typedef struct packed {
		logic       enable;
		logic [3:0] region;
	} dcache_cfg_t;

	typedef enum logic [2:0] {
		IDLE,
		FILL,
		WRITE,
		BYPASS,
		SWEEP
	} dcache_state_e;

endpackage

`default_nettype wire

// File: rtl/dcache_ctrl_regs.sv
// Cache configuration registers
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module dcache_ctrl_regs (
	input  wire logic                i_clock,
	input  wire logic                i_rst_n,
	input  wire bus_pkg::cfg_write_t i_cfg,
	output bus_pkg::dcache_cfg_t     o_cfg
);

	bus_pkg::dcache_cfg_t cfg_q;

	assign o_cfg = cfg_q;

	// Enable at bit 0, region nibble at bits 3:0
	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			cfg_q.enable <= 1'b0;
			cfg_q.region <= `MEM_CFG_REGION_RESET;
		end else if (i_cfg.write) begin
			unique case (i_cfg.addr)
				`MEM_CFG_ADDR_CTRL: begin
					cfg_q.enable <= i_cfg.wdata[0];
				end
				`MEM_CFG_ADDR_REGION: begin
					cfg_q.region <= i_cfg.wdata[3:0];
				end
			endcase
		end
	end

endmodule

`default_nettype wire

// File: rtl/dcache.sv
// Direct-mapped write-through data cache
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module dcache (
	input  wire logic                 i_clock,
	input  wire logic                 i_rst_n,
	input  wire bus_pkg::dcache_cfg_t i_cfg,
	input  wire bus_pkg::bus_req_t    i_req,
	input  wire logic                 i_flush,
	output logic                      o_ready,
	output logic [31:0]               o_rdata,
	output bus_pkg::bus_req_t         o_bus,
	input  wire logic                 i_bus_ready,
	input  wire logic [31:0]          i_bus_rdata
);

	localparam int INDEX_BITS = `MEM_DCACHE_INDEX_BITS;
	localparam int LINES = 1 << INDEX_BITS;
	localparam int TAG_BITS = 30 - INDEX_BITS;

	bus_pkg::dcache_state_e state;
	bus_pkg::bus_req_t      bus_q;

	logic [LINES-1:0]    valid_q;
	logic [TAG_BITS-1:0] tag_q [LINES];
	logic [31:0]         data_q [LINES];

	logic [INDEX_BITS-1:0] index;
	logic [TAG_BITS-1:0]   tag;
	logic [INDEX_BITS-1:0] sweep_idx;
	logic                  sweep_last;
	logic                  enable_q;
	logic                  enable_rise;
	logic                  cacheable;
	logic                  hit;
	logic [31:0]           merged;

	assign index = i_req.address[INDEX_BITS+1:2];
	assign tag = i_req.address[31:INDEX_BITS+2];

	assign cacheable = i_cfg.enable && (i_req.address[31:28] == i_cfg.region);
	assign hit = valid_q[index] && (tag_q[index] == tag);
	assign enable_rise = i_cfg.enable && !enable_q;
	assign sweep_last = &sweep_idx;

	assign o_bus = bus_q;
	assign o_rdata = (state == bus_pkg::BYPASS) ? i_bus_rdata : data_q[index];

	// Write data merged into the held line
	always_comb begin
		merged = data_q[index];
		for (int b = 0; b < 4; b++) begin
			if (i_req.wmask[b])
				merged[b*8 +: 8] = i_req.wdata[b*8 +: 8];
		end
	end

	always_comb begin
		unique case (state)
			bus_pkg::IDLE: begin
				o_ready = i_req.request && !i_flush && !enable_rise &&
					cacheable && !i_req.rw && hit;
			end
			bus_pkg::WRITE, bus_pkg::BYPASS: begin
				o_ready = i_bus_ready;
			end
			bus_pkg::SWEEP: begin
				o_ready = i_req.request && i_flush && sweep_last;
			end
			default: begin
				o_ready = 1'b0;
			end
		endcase
	end

	// ==================================================
	// Control

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= bus_pkg::IDLE;
			bus_q <= '0;
			valid_q <= '0;
			sweep_idx <= '0;
			enable_q <= 1'b0;
		end else begin
			unique case (state)
				bus_pkg::IDLE: begin
					// Enable edge seen only between transfers
					enable_q <= i_cfg.enable;
					if (enable_rise || (i_req.request && i_flush)) begin
						state <= bus_pkg::SWEEP;
					end else if (i_req.request && !(cacheable && !i_req.rw && hit)) begin
						bus_q <= i_req;
						if (!cacheable) begin
							state <= bus_pkg::BYPASS;
						end else if (i_req.rw) begin
							state <= bus_pkg::WRITE;
						end else begin
							bus_q.wmask <= 4'b0000;
							state <= bus_pkg::FILL;
						end
					end
				end

				bus_pkg::FILL: begin
					if (i_bus_ready) begin
						valid_q[index] <= 1'b1;
						bus_q.request <= 1'b0;
						state <= bus_pkg::IDLE;
					end
				end

				bus_pkg::WRITE, bus_pkg::BYPASS: begin
					if (i_bus_ready) begin
						bus_q.request <= 1'b0;
						state <= bus_pkg::IDLE;
					end
				end

				bus_pkg::SWEEP: begin
					valid_q[sweep_idx] <= 1'b0;
					sweep_idx <= sweep_idx + 1'b1;
					if (sweep_last)
						state <= bus_pkg::IDLE;
				end

				default: begin
					state <= bus_pkg::IDLE;
				end
			endcase
		end
	end

	// ==================================================
	// Tag and data arrays

	always_ff @(posedge i_clock) begin
		if (state == bus_pkg::FILL && i_bus_ready) begin
			tag_q[index] <= tag;
			data_q[index] <= i_bus_rdata;
		end else if (state == bus_pkg::WRITE && i_bus_ready && hit) begin
			data_q[index] <= merged;
		end
	end

	a_bus_stable: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		o_bus.request && !i_bus_ready |=> $stable(o_bus));

	a_no_bus_in_sweep: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		state == bus_pkg::SWEEP |-> !o_bus.request);

endmodule

`default_nettype wire

// File: rtl/mem_stage.sv
// Memory pipeline stage
`timescale 1ns/1ps
`default_nettype none

module mem_stage (
	input  wire logic                    i_clock,
	input  wire logic                    i_rst_n,
	input  wire pipe_pkg::execute_data_t i_exec,
	output logic                         o_busy,
	output pipe_pkg::memory_data_t       o_mem,
	output bus_pkg::bus_req_t            o_dc_req,
	output logic                         o_dc_flush,
	input  wire logic                    i_dc_ready,
	input  wire logic [31:0]             i_dc_rdata
);

	pipe_pkg::stage_state_e state;
	pipe_pkg::stage_state_e state_d;
	pipe_pkg::memory_data_t mem_d;
	logic                   last_strobe;
	logic                   pending;
	logic                   complete;
	logic [1:0]             byte_idx;
	logic [31:0]            shifted;
	logic [31:0]            load_data;
	logic [31:0]            store_data;
	logic [3:0]             store_mask;

	// New item while strobes differ
	assign pending = i_exec.strobe != last_strobe;
	assign o_busy = pending && (i_exec.mem_read || i_exec.mem_write || i_exec.mem_flush);

	assign byte_idx = i_exec.mem_address[1:0];
	assign shifted = i_dc_rdata >> {byte_idx, 3'b000};

	// ==================================================
	// Load extension

	always_comb begin
		case (i_exec.mem_width)
			pipe_pkg::MEMW_1: begin
				load_data = {{24{i_exec.mem_signed & shifted[7]}}, shifted[7:0]};
			end
			pipe_pkg::MEMW_2: begin
				load_data = {{16{i_exec.mem_signed & shifted[15]}}, shifted[15:0]};
			end
			default: begin
				load_data = i_dc_rdata;
			end
		endcase
	end

	// ==================================================
	// Store lanes

	always_comb begin
		store_data = i_exec.rd;
		store_mask = 4'b1111;
		case (i_exec.mem_width)
			pipe_pkg::MEMW_1: begin
				store_data = {4{i_exec.rd[7:0]}};
				store_mask = 4'b0001 << byte_idx;
			end
			pipe_pkg::MEMW_2: begin
				store_data = {2{i_exec.rd[15:0]}};
				// Odd offsets write nothing
				if (byte_idx[0])
					store_mask = 4'b0000;
				else if (byte_idx[1])
					store_mask = 4'b1100;
				else
					store_mask = 4'b0011;
			end
			default: begin
				store_data = i_exec.rd;
				store_mask = 4'b1111;
			end
		endcase
	end

	// ==================================================
	// Sequencing

	always_comb begin
		state_d = state;
		complete = 1'b0;
		mem_d = o_mem;
		o_dc_req = '0;
		o_dc_req.address = {i_exec.mem_address[31:2], 2'b00};
		o_dc_flush = 1'b0;

		unique case (state)
			pipe_pkg::IDLE: begin
				if (pending) begin
					if (i_exec.mem_read) begin
						o_dc_req.request = 1'b1;
						complete = i_dc_ready;
					end else if (i_exec.mem_write) begin
						o_dc_req.request = 1'b1;
						o_dc_req.rw = 1'b1;
						o_dc_req.wdata = store_data;
						o_dc_req.wmask = store_mask;
						complete = i_dc_ready;
					end else if (i_exec.mem_flush) begin
						o_dc_req.request = 1'b1;
						o_dc_flush = 1'b1;
						state_d = pipe_pkg::FLUSH;
					end else begin
						complete = 1'b1;
					end
				end
			end

			pipe_pkg::FLUSH: begin
				o_dc_req.request = 1'b1;
				o_dc_flush = 1'b1;
				if (i_dc_ready) begin
					complete = 1'b1;
					state_d = pipe_pkg::IDLE;
				end
			end

			default: begin
				state_d = pipe_pkg::IDLE;
			end
		endcase

		if (complete) begin
			mem_d.strobe = ~o_mem.strobe;
			mem_d.pc = i_exec.pc;
			mem_d.rd = i_exec.mem_read ? load_data : i_exec.rd;
			mem_d.inst_rd = i_exec.mem_read ? i_exec.mem_inst_rd : i_exec.inst_rd;
		end
	end

	always_ff @(posedge i_clock) begin
		if (!i_rst_n) begin
			state <= pipe_pkg::IDLE;
			last_strobe <= 1'b0;
			o_mem <= '0;
		end else begin
			state <= state_d;
			o_mem <= mem_d;
			if (complete)
				last_strobe <= i_exec.strobe;
		end
	end

	// Output toggles only for an accepted item
	a_strobe_pending: assert property (@(posedge i_clock) disable iff (!i_rst_n)
		$past(i_rst_n) && $changed(o_mem.strobe) |-> $past(pending));

endmodule

`default_nettype wire

// File: rtl/mem_subsystem.sv
// Memory stage with data cache
`timescale 1ns/1ps
`default_nettype none

module mem_subsystem (
	input  wire logic                    i_clock,
	input  wire logic                    i_rst_n,
	input  wire pipe_pkg::execute_data_t i_exec,
	output logic                         o_busy,
	output pipe_pkg::memory_data_t       o_mem,
	input  wire bus_pkg::cfg_write_t     i_cfg,
	output bus_pkg::bus_req_t            o_bus,
	input  wire logic                    i_bus_ready,
	input  wire logic [31:0]             i_bus_rdata
);

	bus_pkg::bus_req_t    dc_req;
	bus_pkg::dcache_cfg_t dc_cfg;
	logic                 dc_flush;
	logic                 dc_ready;
	logic [31:0]          dc_rdata;

	mem_stage u_stage (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_exec     (i_exec),
		.o_busy     (o_busy),
		.o_mem      (o_mem),
		.o_dc_req   (dc_req),
		.o_dc_flush (dc_flush),
		.i_dc_ready (dc_ready),
		.i_dc_rdata (dc_rdata)
	);

	dcache u_dcache (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.i_cfg       (dc_cfg),
		.i_req       (dc_req),
		.i_flush     (dc_flush),
		.o_ready     (dc_ready),
		.o_rdata     (dc_rdata),
		.o_bus       (o_bus),
		.i_bus_ready (i_bus_ready),
		.i_bus_rdata (i_bus_rdata)
	);

	dcache_ctrl_regs u_regs (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.i_cfg   (i_cfg),
		.o_cfg   (dc_cfg)
	);

endmodule

`default_nettype wire

// File: tests/bus_ram_model.sv
// Bus memory with random latency
`timescale 1ns/1ps
`default_nettype none

module bus_ram_model (
	input  wire logic              i_clock,
	input  wire bus_pkg::bus_req_t i_bus,
	output logic                   o_ready,
	output logic [31:0]            o_rdata,
	output int                     o_read_count
);

	localparam int WORDS = 1024;
	localparam logic [31:0] FILL_KEY = 32'h9E37_79B9;

	logic [31:0] mem [WORDS];
	logic [31:0] lcg_state;
	logic [31:0] lcg_step;
	logic [1:0]  delay;
	logic [9:0]  word_idx;

	function automatic logic [31:0] lcg_next(input logic [31:0] s);
		return s * 32'd1103515245 + 32'd12345;
	endfunction

	// Region nibble and low word bits pick the word
	assign word_idx = {i_bus.address[31:28], i_bus.address[7:2]};
	assign o_ready = i_bus.request && (delay == 2'd0);
	assign o_rdata = mem[word_idx];
	assign lcg_step = lcg_next(lcg_state);

	initial begin
		logic [31:0] addr;
		logic [31:0] seed;
		for (int i = 0; i < WORDS; i++) begin
			addr = {i[9:6], 20'h0, i[5:0], 2'b00};
			mem[i] = addr ^ FILL_KEY;
		end
		seed = lcg_next(32'd70);
		lcg_state = seed;
		delay = seed[17:16];
		o_read_count = 0;
	end

	always @(posedge i_clock) begin
		if (i_bus.request) begin
			if (delay != 2'd0) begin
				delay <= delay - 2'd1;
			end else begin
				if (i_bus.rw) begin
					for (int b = 0; b < 4; b++) begin
						if (i_bus.wmask[b])
							mem[word_idx][b*8 +: 8] <= i_bus.wdata[b*8 +: 8];
					end
				end else begin
					o_read_count <= o_read_count + 1;
				end
				// Latency of the next transfer is 0 to 3 cycles
				lcg_state <= lcg_step;
				delay <= lcg_step[17:16];
			end
		end
	end

endmodule

`default_nettype wire

// File: tests/tb_mem_subsystem.sv
// Memory subsystem testbench
`timescale 1ns/1ps
`default_nettype none

`include "mem_params.svh"

module tb_mem_subsystem;

	typedef struct packed {
		bus_pkg::cfg_write_t     cfg;
		pipe_pkg::execute_data_t item;
		logic [31:0]             exp_rd;
		logic [1:0]              exp_reads;
	} test_entry_t;

	// Memory words hold their byte address xor 0x9E3779B9
	localparam logic [31:0] ADDR_A = 32'h1000_0040;
	localparam logic [31:0] ADDR_B = 32'h1000_0080;
	localparam logic [31:0] ADDR_U = 32'h2000_0010;

	logic                    clock;
	logic                    rst_n;
	pipe_pkg::execute_data_t exec;
	pipe_pkg::memory_data_t  mem_out;
	bus_pkg::cfg_write_t     cfg;
	bus_pkg::bus_req_t       bus;
	logic                    busy;
	logic                    bus_ready;
	logic [31:0]             bus_rdata;
	int                      read_count;

	test_entry_t entries[$];
	string       names[$];
	bit          table_built;
	int          errors;

	mem_subsystem dut (
		.i_clock     (clock),
		.i_rst_n     (rst_n),
		.i_exec      (exec),
		.o_busy      (busy),
		.o_mem       (mem_out),
		.i_cfg       (cfg),
		.o_bus       (bus),
		.i_bus_ready (bus_ready),
		.i_bus_rdata (bus_rdata)
	);

	bus_ram_model ram (
		.i_clock      (clock),
		.i_bus        (bus),
		.o_ready      (bus_ready),
		.o_rdata      (bus_rdata),
		.o_read_count (read_count)
	);

	initial begin
		clock = 1'b0;
		forever #10 clock = ~clock;
	end

	// ==================================================
	// Item builders

	function automatic bus_pkg::cfg_write_t cfg_set(input logic addr, input logic [31:0] data);
		bus_pkg::cfg_write_t c;
		c.write = 1'b1;
		c.addr = addr;
		c.wdata = data;
		return c;
	endfunction

	function automatic pipe_pkg::execute_data_t load_item(input logic [31:0] addr,
		input pipe_pkg::mem_width_e width, input logic sign);
		pipe_pkg::execute_data_t it;
		it = '0;
		it.mem_read = 1'b1;
		it.mem_address = addr;
		it.mem_width = width;
		it.mem_signed = sign;
		return it;
	endfunction

	function automatic pipe_pkg::execute_data_t store_item(input logic [31:0] addr,
		input pipe_pkg::mem_width_e width, input logic [31:0] data);
		pipe_pkg::execute_data_t it;
		it = '0;
		it.mem_write = 1'b1;
		it.mem_address = addr;
		it.mem_width = width;
		it.rd = data;
		return it;
	endfunction

	function automatic pipe_pkg::execute_data_t alu_item(input logic [31:0] data);
		pipe_pkg::execute_data_t it;
		it = '0;
		it.rd = data;
		return it;
	endfunction

	function automatic pipe_pkg::execute_data_t flush_item();
		pipe_pkg::execute_data_t it;
		it = '0;
		it.mem_flush = 1'b1;
		return it;
	endfunction

	task automatic add_case(input string name, input bus_pkg::cfg_write_t c,
		input pipe_pkg::execute_data_t it, input logic [31:0] rd, input logic [1:0] reads);
		test_entry_t e;
		e.cfg = c;
		e.item = it;
		e.exp_rd = rd;
		e.exp_reads = reads;
		entries.push_back(e);
		names.push_back(name);
	endtask

	task automatic build_table();
		add_case("alu_pass", '0, alu_item(32'h1234_5678), 32'h1234_5678, 2'd0);
		add_case("lbu_a0", '0, load_item(ADDR_A, pipe_pkg::MEMW_1, 1'b0), 32'h0000_00F9, 2'd1);
		add_case("lb_a0", '0, load_item(ADDR_A, pipe_pkg::MEMW_1, 1'b1), 32'hFFFF_FFF9, 2'd1);
		add_case("lb_a1", '0, load_item(ADDR_A + 1, pipe_pkg::MEMW_1, 1'b1), 32'h0000_0079, 2'd1);
		add_case("lbu_a3", '0, load_item(ADDR_A + 3, pipe_pkg::MEMW_1, 1'b0), 32'h0000_008E, 2'd1);
		add_case("lh_a2", '0, load_item(ADDR_A + 2, pipe_pkg::MEMW_2, 1'b1), 32'hFFFF_8E37, 2'd1);
		add_case("lhu_a2", '0, load_item(ADDR_A + 2, pipe_pkg::MEMW_2, 1'b0), 32'h0000_8E37, 2'd1);
		add_case("lh_a0", '0, load_item(ADDR_A, pipe_pkg::MEMW_2, 1'b1), 32'h0000_79F9, 2'd1);
		add_case("lw_a", '0, load_item(ADDR_A, pipe_pkg::MEMW_4, 1'b0), 32'h8E37_79F9, 2'd1);
		// Byte lanes and masks with the cache still off
		add_case("sb_b1", '0, store_item(ADDR_B + 1, pipe_pkg::MEMW_1, 32'hC4), 32'hC4, 2'd0);
		add_case("sh_b2", '0, store_item(ADDR_B + 2, pipe_pkg::MEMW_2, 32'h1357), 32'h1357, 2'd0);
		add_case("sh_b1_odd", '0, store_item(ADDR_B + 1, pipe_pkg::MEMW_2, 32'hFFFF), 32'hFFFF,
			2'd0);
		add_case("lw_b_merge", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h1357_C439, 2'd1);
		// Cache on
		add_case("en_lw_b_miss", cfg_set(`MEM_CFG_ADDR_CTRL, 32'h1),
			load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h1357_C439, 2'd1);
		add_case("lw_b_hit", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h1357_C439, 2'd0);
		add_case("lw_u_1", '0, load_item(ADDR_U, pipe_pkg::MEMW_4, 1'b0), 32'hBE37_79A9, 2'd1);
		add_case("lw_u_2", '0, load_item(ADDR_U, pipe_pkg::MEMW_4, 1'b0), 32'hBE37_79A9, 2'd1);
		add_case("sw_b_hit", '0, store_item(ADDR_B, pipe_pkg::MEMW_4, 32'hCAFE_0001),
			32'hCAFE_0001, 2'd0);
		add_case("lw_b_new", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'hCAFE_0001, 2'd0);
		add_case("sb_b3_hit", '0, store_item(ADDR_B + 3, pipe_pkg::MEMW_1, 32'h5A), 32'h5A, 2'd0);
		add_case("lw_b_hit_merge", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h5AFE_0001,
			2'd0);
		add_case("flush", '0, flush_item(), 32'h0, 2'd0);
		add_case("lw_b_flushed", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h5AFE_0001,
			2'd1);
		add_case("lw_b_refill_hit", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h5AFE_0001,
			2'd0);
		// Cache off and back on
		add_case("dis_lw_b", cfg_set(`MEM_CFG_ADDR_CTRL, 32'h0),
			load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h5AFE_0001, 2'd1);
		add_case("dis_lw_b_again", '0, load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h5AFE_0001,
			2'd1);
		add_case("reen_lw_b_miss", cfg_set(`MEM_CFG_ADDR_CTRL, 32'h1),
			load_item(ADDR_B, pipe_pkg::MEMW_4, 1'b0), 32'h5AFE_0001, 2'd1);
		add_case("reen_lbu_b3_hit", '0, load_item(ADDR_B + 3, pipe_pkg::MEMW_1, 1'b0),
			32'h0000_005A, 2'd0);
	endtask

	task automatic report_mismatch(input string name, input string field,
		input logic [31:0] expected, input logic [31:0] actual);
		errors++;
		$display("[FAIL] %s %s: expected %h, actual %h", name, field, expected, actual);
	endtask

	// ==================================================
	// One table entry

	task automatic run_case(input int idx);
		test_entry_t             e;
		pipe_pkg::execute_data_t it;
		int                      reads_before;
		logic                    exp_busy;
		logic [4:0]              exp_inst;
		e = entries[idx];
		if (e.cfg.write) begin
			cfg = e.cfg;
			@(negedge clock);
			cfg = '0;
		end
		it = e.item;
		it.pc = 32'h0000_0400 + 32'(idx) * 4;
		it.inst_rd = 5'(idx);
		it.mem_inst_rd = ~5'(idx);
		it.strobe = ~exec.strobe;
		exp_busy = it.mem_read | it.mem_write | it.mem_flush;
		exp_inst = it.mem_read ? it.mem_inst_rd : it.inst_rd;
		reads_before = read_count;
		exec = it;
		#1;
		if (busy !== exp_busy)
			report_mismatch(names[idx], "o_busy", 32'(exp_busy), 32'(busy));
		while (mem_out.strobe !== it.strobe)
			@(negedge clock);
		if (mem_out.pc !== it.pc)
			report_mismatch(names[idx], "pc", it.pc, mem_out.pc);
		if (mem_out.rd !== e.exp_rd)
			report_mismatch(names[idx], "rd", e.exp_rd, mem_out.rd);
		if (mem_out.inst_rd !== exp_inst)
			report_mismatch(names[idx], "inst_rd", 32'(exp_inst), 32'(mem_out.inst_rd));
		if (read_count - reads_before != int'(e.exp_reads))
			report_mismatch(names[idx], "bus reads", 32'(e.exp_reads),
				32'(read_count - reads_before));
	endtask

	initial begin
		rst_n = 1'b0;
		exec = '0;
		cfg = '0;
		errors = 0;
		table_built = 1'b0;
		build_table();
		table_built = 1'b1;
		repeat (5) @(posedge clock);
		@(negedge clock);
		rst_n = 1'b1;
		if (mem_out !== '0) begin
			errors++;
			$display("[FAIL] reset o_mem: expected 0, actual %h", mem_out);
		end
		if (bus.request !== 1'b0) begin
			errors++;
			$display("[FAIL] reset o_bus.request: expected 0, actual %b", bus.request);
		end
		for (int i = 0; i < entries.size(); i++)
			run_case(i);
		$display("Cases: %0d, errors: %0d", entries.size(), errors);
		if (errors == 0)
			$display("TESTBENCH PASSED");
		else
			$display("TESTBENCH FAILED");
		$finish;
	end

	// Watchdog of 200 cycles per table entry
	initial begin
		wait (table_built);
		repeat (entries.size() * 200) @(posedge clock);
		$display("Timeout: the table did not finish within %0d cycles", entries.size() * 200);
		$display("Cases: %0d, errors: %0d", entries.size(), errors);
		$display("TESTBENCH FAILED");
		$finish;
	end

endmodule

`default_nettype wire

// File: all.f
+incdir+rtl
rtl/pipe_pkg.sv
rtl/bus_pkg.sv
rtl/dcache_ctrl_regs.sv
rtl/dcache.sv
rtl/mem_stage.sv
rtl/mem_subsystem.sv
tests/bus_ram_model.sv
tests/tb_mem_subsystem.sv
